// ==== isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // primary opcode in the top six bits
    typedef enum logic [5:0] {
        op_nop = 6'd0,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_addi,
        op_lui,
        op_ld,
        op_st
    } opcode_t;

    localparam int op_hi  = 31;
    localparam int op_lo  = 26;
    localparam int rd_hi  = 25;
    localparam int rd_lo  = 21;
    localparam int rj_hi  = 20;
    localparam int rj_lo  = 16;
    localparam int rk_hi  = 15; // overlaps imm16 upper bits
    localparam int rk_lo  = 11;
    localparam int imm_hi = 15;
    localparam int imm_lo = 0;

endpackage

`default_nettype wire

// ==== pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass2 // lui, src2 straight through
    } alu_op_t;

    typedef struct packed {
        alu_op_t     alu_op;
        logic [31:0] src1;
        logic [31:0] src2;
        logic [31:0] rkd_value;   // store data
        logic        res_from_mem;
        logic        mem_we;
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic [31:0] pc;
    } id_to_ex_t;

    // result a later stage offers back to decode
    typedef struct packed {
        logic        rf_we;   // already qualified by stage valid
        logic        is_load;
        logic [4:0]  waddr;
        logic [31:0] value;
    } fwd_t;

    typedef struct packed {
        logic [31:0] pc;
        logic        res_from_mem;
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic [31:0] alu_result;
    } ex_to_mem_t;

    typedef struct packed {
        logic [31:0] pc;
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic [31:0] wdata;
    } mem_to_wb_t;

endpackage

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire pipe_pkg::alu_op_t alu_op,
    input  wire [31:0]             alu_src1,
    input  wire [31:0]             alu_src2,
    output logic [31:0]            alu_result
);

    logic lt;

    assign lt = $signed(alu_src1) < $signed(alu_src2); // signed compare

    always_comb begin
        case (alu_op)
            pipe_pkg::alu_add:   alu_result = alu_src1 + alu_src2;
            pipe_pkg::alu_sub:   alu_result = alu_src1 - alu_src2;
            pipe_pkg::alu_and:   alu_result = alu_src1 & alu_src2;
            pipe_pkg::alu_or:    alu_result = alu_src1 | alu_src2;
            pipe_pkg::alu_xor:   alu_result = alu_src1 ^ alu_src2;
            pipe_pkg::alu_slt:   alu_result = {31'd0, lt};
            pipe_pkg::alu_pass2: alu_result = alu_src2;
            default:             alu_result = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire         clk,
    input  wire  [4:0]  raddr1,
    input  wire  [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  wire         we,
    input  wire  [4:0]  waddr,
    input  wire  [31:0] wdata
);

    logic [31:0] regs [31:1]; // r0 has no storage

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // write-through so a same-cycle writeback is seen by decode
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 :
                    (we && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 :
                    (we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

// ==== if_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module if_stage #(
    parameter logic [31:0] reset_pc = 32'h0
) (
    input  wire         clk,
    input  wire         resetn,
    input  wire         id_allowin,
    output logic        if_to_id_valid,
    output logic [31:0] if_pc,
    output logic        inst_sram_en,
    output logic [31:0] inst_sram_addr
);

    logic        fetch_on;  // low through reset
    logic [31:0] fetch_pc;  // address of the next request

    // request goes out only when decode can take the returning word
    assign inst_sram_en   = fetch_on & id_allowin;
    assign inst_sram_addr = fetch_pc;
    assign if_to_id_valid = fetch_on;
    assign if_pc          = fetch_pc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fetch_on <= 1'b0;
            fetch_pc <= reset_pc;
        end else begin
            fetch_on <= 1'b1;
            if (inst_sram_en) begin
                fetch_pc <= fetch_pc + 32'd4; // sequential only
            end
        end
    end

endmodule

`default_nettype wire

// ==== id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  wire                  clk,
    input  wire                  resetn,
    input  wire                  if_to_id_valid,
    input  wire [31:0]           if_pc,
    input  wire [31:0]           inst_sram_rdata,
    output logic                 id_allowin,
    input  wire                  ex_allowin,
    output logic                 id_to_ex_valid,
    output pipe_pkg::id_to_ex_t  id_to_ex_bus,
    input  wire pipe_pkg::fwd_t  ex_fwd,
    input  wire pipe_pkg::fwd_t  mem_fwd,
    input  wire pipe_pkg::fwd_t  wb_fwd,
    output logic [4:0]           rf_raddr1,
    output logic [4:0]           rf_raddr2,
    input  wire [31:0]           rf_rdata1,
    input  wire [31:0]           rf_rdata2
);

    logic              id_valid;
    logic [31:0]       id_pc;
    logic [31:0]       inst;
    isa_pkg::opcode_t  op;
    logic [4:0]        rd;
    logic [4:0]        rj;
    logic              is_rr;
    logic              is_addi;
    logic              is_lui;
    logic              is_ld;
    logic              is_st;
    logic              use_rj;
    logic              use_r2;
    pipe_pkg::alu_op_t alu_op;
    logic [31:0]       imm;
    logic [31:0]       rj_value;
    logic [31:0]       r2_value;
    logic              hazard;
    logic              id_ready_go;

    // youngest producer wins, EX before MEM before WB
    function automatic logic [31:0] fwd_pick(
        input logic [4:0]     ra,
        input logic [31:0]    rf_val,
        input pipe_pkg::fwd_t e,
        input pipe_pkg::fwd_t m,
        input pipe_pkg::fwd_t w
    );
        logic [31:0] v;
        v = rf_val;
        if (ra != 5'd0) begin
            if (e.rf_we && e.waddr == ra)
                v = e.value;
            else if (m.rf_we && m.waddr == ra)
                v = m.value;
            else if (w.rf_we && w.waddr == ra)
                v = w.value;
        end
        return v;
    endfunction

    assign inst = inst_sram_rdata; // word returned for id_pc
    assign op   = isa_pkg::opcode_t'(inst[isa_pkg::op_hi:isa_pkg::op_lo]);
    assign rd   = inst[isa_pkg::rd_hi:isa_pkg::rd_lo];
    assign rj   = inst[isa_pkg::rj_hi:isa_pkg::rj_lo];

    assign is_rr   = op inside {isa_pkg::op_add, isa_pkg::op_sub, isa_pkg::op_and,
                                isa_pkg::op_or, isa_pkg::op_xor, isa_pkg::op_slt};
    assign is_addi = op == isa_pkg::op_addi;
    assign is_lui  = op == isa_pkg::op_lui;
    assign is_ld   = op == isa_pkg::op_ld;
    assign is_st   = op == isa_pkg::op_st;
    assign use_rj  = is_rr | is_addi | is_ld | is_st;
    assign use_r2  = is_rr | is_st;

    always_comb begin
        case (op)
            isa_pkg::op_sub: alu_op = pipe_pkg::alu_sub;
            isa_pkg::op_and: alu_op = pipe_pkg::alu_and;
            isa_pkg::op_or:  alu_op = pipe_pkg::alu_or;
            isa_pkg::op_xor: alu_op = pipe_pkg::alu_xor;
            isa_pkg::op_slt: alu_op = pipe_pkg::alu_slt;
            isa_pkg::op_lui: alu_op = pipe_pkg::alu_pass2;
            default:         alu_op = pipe_pkg::alu_add; // add, addi, address calc
        endcase
    end

    assign imm = is_lui ? {inst[isa_pkg::imm_hi:isa_pkg::imm_lo], 16'd0}
                        : {{16{inst[isa_pkg::imm_hi]}}, inst[isa_pkg::imm_hi:isa_pkg::imm_lo]};

    assign rf_raddr1 = rj;
    assign rf_raddr2 = is_st ? rd : inst[isa_pkg::rk_hi:isa_pkg::rk_lo]; // store data in rd

    assign rj_value = fwd_pick(rf_raddr1, rf_rdata1, ex_fwd, mem_fwd, wb_fwd);
    assign r2_value = fwd_pick(rf_raddr2, rf_rdata2, ex_fwd, mem_fwd, wb_fwd);

    // load in EX cannot forward yet
    assign hazard = id_valid && ex_fwd.rf_we && ex_fwd.is_load &&
                    ((use_rj && rf_raddr1 != 5'd0 && ex_fwd.waddr == rf_raddr1) ||
                     (use_r2 && rf_raddr2 != 5'd0 && ex_fwd.waddr == rf_raddr2));

    assign id_ready_go    = ~hazard;
    assign id_allowin     = ~id_valid | id_ready_go & ex_allowin;
    assign id_to_ex_valid = id_valid & id_ready_go; // bubble into EX on stall

    always_comb begin
        id_to_ex_bus.alu_op       = alu_op;
        id_to_ex_bus.src1         = rj_value;
        id_to_ex_bus.src2         = is_rr ? r2_value : imm;
        id_to_ex_bus.rkd_value    = r2_value;
        id_to_ex_bus.res_from_mem = is_ld;
        id_to_ex_bus.mem_we       = is_st;
        id_to_ex_bus.rf_we        = is_rr | is_addi | is_lui | is_ld;
        id_to_ex_bus.rf_waddr     = rd;
        id_to_ex_bus.pc           = id_pc;
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            id_valid <= 1'b0;
        else if (id_allowin)
            id_valid <= if_to_id_valid;
    end

    always_ff @(posedge clk) begin
        if (if_to_id_valid && id_allowin)
            id_pc <= if_pc;
    end

endmodule

`default_nettype wire

// ==== ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     id_to_ex_valid,
    input  wire pipe_pkg::id_to_ex_t id_to_ex_bus,
    output logic                    ex_allowin,
    input  wire                     mem_allowin,
    output logic                    ex_to_mem_valid,
    output pipe_pkg::ex_to_mem_t    ex_to_mem_bus,
    output pipe_pkg::fwd_t          ex_fwd,
    output logic                    data_sram_en,
    output logic [3:0]              data_sram_we,
    output logic [31:0]             data_sram_addr,
    output logic [31:0]             data_sram_wdata
);

    logic                ex_valid;
    pipe_pkg::id_to_ex_t ex_r;
    logic [31:0]         ex_alu_result;

    assign ex_allowin      = ~ex_valid | mem_allowin; // single-cycle ALU, always ready
    assign ex_to_mem_valid = ex_valid;

    always_ff @(posedge clk) begin
        if (!resetn)
            ex_valid <= 1'b0;
        else if (ex_allowin)
            ex_valid <= id_to_ex_valid;
    end

    always_ff @(posedge clk) begin
        if (id_to_ex_valid && ex_allowin)
            ex_r <= id_to_ex_bus;
    end

    alu u_alu (
        .alu_op     (ex_r.alu_op),
        .alu_src1   (ex_r.src1),
        .alu_src2   (ex_r.src2),
        .alu_result (ex_alu_result)
    );

    // sync SRAM so the address goes out a cycle ahead of MEM
    assign data_sram_en    = ex_valid & (ex_r.res_from_mem | ex_r.mem_we);
    assign data_sram_we    = {4{ex_valid & ex_r.mem_we}}; // word stores only
    assign data_sram_addr  = ex_alu_result;
    assign data_sram_wdata = ex_r.rkd_value;

    assign ex_fwd.rf_we   = ex_valid & ex_r.rf_we;
    assign ex_fwd.is_load = ex_valid & ex_r.res_from_mem;
    assign ex_fwd.waddr   = ex_r.rf_waddr;
    assign ex_fwd.value   = ex_alu_result;

    assign ex_to_mem_bus.pc           = ex_r.pc;
    assign ex_to_mem_bus.res_from_mem = ex_r.res_from_mem;
    assign ex_to_mem_bus.rf_we        = ex_r.rf_we;
    assign ex_to_mem_bus.rf_waddr     = ex_r.rf_waddr;
    assign ex_to_mem_bus.alu_result   = ex_alu_result;

endmodule

`default_nettype wire

// ==== mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire                      ex_to_mem_valid,
    input  wire pipe_pkg::ex_to_mem_t ex_to_mem_bus,
    output logic                     mem_allowin,
    input  wire                      wb_allowin,
    output logic                     mem_to_wb_valid,
    output pipe_pkg::mem_to_wb_t     mem_to_wb_bus,
    input  wire [31:0]               data_sram_rdata,
    output pipe_pkg::fwd_t           mem_fwd
);

    logic                 mem_valid;
    pipe_pkg::ex_to_mem_t mem_r;
    logic [31:0]          mem_result;

    assign mem_allowin     = ~mem_valid | wb_allowin; // always ready
    assign mem_to_wb_valid = mem_valid;

    always_ff @(posedge clk) begin
        if (!resetn)
            mem_valid <= 1'b0;
        else if (mem_allowin)
            mem_valid <= ex_to_mem_valid;
    end

    always_ff @(posedge clk) begin
        if (ex_to_mem_valid && mem_allowin)
            mem_r <= ex_to_mem_bus;
    end

    assign mem_result = mem_r.res_from_mem ? data_sram_rdata : mem_r.alu_result;

    assign mem_to_wb_bus = '{pc: mem_r.pc, rf_we: mem_r.rf_we,
                             rf_waddr: mem_r.rf_waddr, wdata: mem_result};

    // load data is already here, so MEM forwards it
    assign mem_fwd = '{rf_we: mem_valid & mem_r.rf_we, is_load: mem_valid & mem_r.res_from_mem,
                       waddr: mem_r.rf_waddr, value: mem_result};

endmodule

`default_nettype wire

// ==== wb_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire                      mem_to_wb_valid,
    input  wire pipe_pkg::mem_to_wb_t mem_to_wb_bus,
    output logic                     wb_allowin,
    output logic                     rf_we,
    output logic [4:0]               rf_waddr,
    output logic [31:0]              rf_wdata,
    output pipe_pkg::fwd_t           wb_fwd,
    output logic [31:0]              debug_wb_pc,
    output logic                     debug_wb_rf_we,
    output logic [4:0]               debug_wb_rf_waddr,
    output logic [31:0]              debug_wb_rf_wdata
);

    logic                 wb_valid;
    pipe_pkg::mem_to_wb_t wb_r;

    assign wb_allowin = 1'b1; // last stage never stalls

    always_ff @(posedge clk) begin
        if (!resetn)
            wb_valid <= 1'b0;
        else
            wb_valid <= mem_to_wb_valid;
    end

    always_ff @(posedge clk) begin
        if (mem_to_wb_valid)
            wb_r <= mem_to_wb_bus;
    end

    assign rf_we    = wb_valid & wb_r.rf_we;
    assign rf_waddr = wb_r.rf_waddr;
    assign rf_wdata = wb_r.wdata;

    assign wb_fwd = '{rf_we: rf_we, is_load: 1'b0, waddr: rf_waddr, value: rf_wdata};

    // trace mirrors the register write of this cycle
    assign debug_wb_pc       = wb_r.pc;
    assign debug_wb_rf_we    = rf_we;
    assign debug_wb_rf_waddr = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

`default_nettype wire

// ==== mini_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module mini_core #(
    parameter logic [31:0] reset_pc = 32'h0
) (
    input  wire         clk,
    input  wire         resetn,
    output logic        inst_sram_en,
    output logic [31:0] inst_sram_addr,
    input  wire  [31:0] inst_sram_rdata,
    output logic        data_sram_en,
    output logic [3:0]  data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  wire  [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic        debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_waddr,
    output logic [31:0] debug_wb_rf_wdata
);

    logic                 id_allowin;
    logic                 ex_allowin;
    logic                 mem_allowin;
    logic                 wb_allowin;
    logic                 if_to_id_valid;
    logic                 id_to_ex_valid;
    logic                 ex_to_mem_valid;
    logic                 mem_to_wb_valid;
    logic [31:0]          if_pc;
    pipe_pkg::id_to_ex_t  id_to_ex_bus;
    pipe_pkg::ex_to_mem_t ex_to_mem_bus;
    pipe_pkg::mem_to_wb_t mem_to_wb_bus;
    pipe_pkg::fwd_t       ex_fwd;
    pipe_pkg::fwd_t       mem_fwd;
    pipe_pkg::fwd_t       wb_fwd;
    logic [4:0]           rf_raddr1;
    logic [4:0]           rf_raddr2;
    logic [31:0]          rf_rdata1;
    logic [31:0]          rf_rdata2;
    logic                 rf_we;
    logic [4:0]           rf_waddr;
    logic [31:0]          rf_wdata;

    if_stage #(.reset_pc(reset_pc)) u_if (
        .clk, .resetn, .id_allowin, .if_to_id_valid, .if_pc,
        .inst_sram_en, .inst_sram_addr
    );

    id_stage u_id (
        .clk, .resetn, .if_to_id_valid, .if_pc, .inst_sram_rdata,
        .id_allowin, .ex_allowin, .id_to_ex_valid, .id_to_ex_bus,
        .ex_fwd, .mem_fwd, .wb_fwd,
        .rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2
    );

    ex_stage u_ex (
        .clk, .resetn, .id_to_ex_valid, .id_to_ex_bus, .ex_allowin,
        .mem_allowin, .ex_to_mem_valid, .ex_to_mem_bus, .ex_fwd,
        .data_sram_en, .data_sram_we, .data_sram_addr, .data_sram_wdata
    );

    mem_stage u_mem (
        .clk, .resetn, .ex_to_mem_valid, .ex_to_mem_bus, .mem_allowin,
        .wb_allowin, .mem_to_wb_valid, .mem_to_wb_bus,
        .data_sram_rdata, .mem_fwd
    );

    wb_stage u_wb (
        .clk, .resetn, .mem_to_wb_valid, .mem_to_wb_bus, .wb_allowin,
        .rf_we, .rf_waddr, .rf_wdata, .wb_fwd,
        .debug_wb_pc, .debug_wb_rf_we, .debug_wb_rf_waddr, .debug_wb_rf_wdata
    );

    regfile u_rf (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    initial begin
        resetn = 1'b0;
        repeat (3) @(posedge clk);
        #1 resetn = 1'b1; // released just after the third edge
    end

endmodule

`default_nettype wire

// ==== tb_mini_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mini_core;

    localparam logic [31:0] boot_pc = 32'h0000_0100;
    localparam int          n_tests = 7;

    typedef struct packed {
        isa_pkg::opcode_t op;
        logic [4:0]       rd;
        logic [4:0]       rj;
        logic [15:0]      imm;    // rk sits in the top five bits
        logic [31:0]      value;  // expected write value
        logic             has_wr;
        logic [3:0]       test;
    } prog_entry_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        logic [3:0]  test;
        logic        last;   // final write of its test
    } wr_entry_t;

    logic        clk;
    logic        resetn;
    logic        inst_sram_en;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic        debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_waddr;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:63];
    logic [31:0] ref_dm [0:63];   // reference data memory
    logic [31:0] ref_rf [0:31];   // reference register file
    prog_entry_t prog [$];
    wr_entry_t   exp_q [$];
    string       test_name [0:n_tests-1];
    int          test_errs [0:n_tests-1];
    int          checks = 0;
    int          errors = 0;
    int          cur_test = 0;
    int          cycles = 0;
    integer      seed;

    tb_clk_gen u_clk (.clk, .resetn);

    mini_core #(.reset_pc(boot_pc)) u_dut (
        .clk, .resetn,
        .inst_sram_en, .inst_sram_addr, .inst_sram_rdata,
        .data_sram_en, .data_sram_we, .data_sram_addr, .data_sram_wdata, .data_sram_rdata,
        .debug_wb_pc, .debug_wb_rf_we, .debug_wb_rf_waddr, .debug_wb_rf_wdata
    );

    function automatic logic [31:0] fill_word(input int i);
        return 32'hd00d_0000 | (32'(i) << 2);
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errs[cur_test]++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_test(input int t);
        $display("test %0d %s done, %0d errors", t, test_name[t], test_errs[t]);
    endtask

    // appends one instruction and works out its result from the ISA rules
    task automatic add_inst(input isa_pkg::opcode_t op, input logic [4:0] rd,
                            input logic [4:0] rj, input logic [15:0] imm, input int test);
        prog_entry_t p;
        logic [31:0] sx;
        logic [31:0] a;
        logic [4:0]  rk;
        sx = {{16{imm[15]}}, imm};
        rk = imm[15:11];
        a = ref_rf[rj] + sx;
        p = '{op: op, rd: rd, rj: rj, imm: imm, value: 32'd0, has_wr: 1'b1, test: 4'(test)};
        case (op)
            isa_pkg::op_add:  p.value = ref_rf[rj] + ref_rf[rk];
            isa_pkg::op_sub:  p.value = ref_rf[rj] - ref_rf[rk];
            isa_pkg::op_and:  p.value = ref_rf[rj] & ref_rf[rk];
            isa_pkg::op_or:   p.value = ref_rf[rj] | ref_rf[rk];
            isa_pkg::op_xor:  p.value = ref_rf[rj] ^ ref_rf[rk];
            isa_pkg::op_slt:  p.value = ($signed(ref_rf[rj]) < $signed(ref_rf[rk])) ? 32'd1 : 32'd0;
            isa_pkg::op_addi: p.value = a;
            isa_pkg::op_lui:  p.value = {imm, 16'd0};
            isa_pkg::op_ld:   p.value = ref_dm[a[7:2]];
            isa_pkg::op_st: begin
                ref_dm[a[7:2]] = ref_rf[rd]; // data register in rd
                p.has_wr = 1'b0;
            end
            default:          p.has_wr = 1'b0;
        endcase
        if (p.has_wr && rd != 5'd0)
            ref_rf[rd] = p.value;
        prog.push_back(p);
    endtask

    task automatic add_rr(input isa_pkg::opcode_t op, input logic [4:0] rd,
                          input logic [4:0] rj, input logic [4:0] rk, input int test);
        add_inst(op, rd, rj, {rk, 11'd0}, test);
    endtask

    // sync instruction SRAM, holds its output when not enabled
    always @(posedge clk) begin : imem_model
        logic        en;
        logic [31:0] addr;
        en = inst_sram_en;
        addr = inst_sram_addr;
        #1;
        if (en)
            inst_sram_rdata = imem[addr[9:2]];
    end

    always @(posedge clk) begin : dmem_model
        logic        en;
        logic [3:0]  we;
        logic [31:0] addr;
        logic [31:0] wdata;
        en = data_sram_en;
        we = data_sram_we;
        addr = data_sram_addr;
        wdata = data_sram_wdata;
        #1;
        if (en) begin
            data_sram_rdata = dmem[addr[7:2]]; // old word on a write
            for (int b = 0; b < 4; b++) begin
                if (we[b])
                    dmem[addr[7:2]][8*b +: 8] = wdata[8*b +: 8];
            end
        end
    end

    always @(posedge clk) begin
        if (resetn)
            cycles <= cycles + 1;
    end

    // retired writes must match the expected list in order
    always @(negedge clk) begin : wb_monitor
        wr_entry_t e;
        if (resetn && debug_wb_rf_we) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("register write to r%0d at pc %h when none was expected",
                         debug_wb_rf_waddr, debug_wb_pc);
            end else begin
                e = exp_q.pop_front();
                cur_test = e.test;
                check_val("debug_wb_pc", debug_wb_pc, e.pc);
                check_val("debug_wb_rf_waddr", 32'(debug_wb_rf_waddr), 32'(e.waddr));
                check_val("debug_wb_rf_wdata", debug_wb_rf_wdata, e.wdata);
                if (e.last)
                    report_test(e.test);
            end
        end
    end

    initial begin : main
        logic [31:0] rnd;
        logic [7:0]  idx;
        wr_entry_t   w;
        int          limit;
        int          clean;

        inst_sram_rdata = 32'd0;
        data_sram_rdata = 32'd0;
        seed = 32'h15a0;
        test_name[0] = "reset";
        test_name[1] = "alu_forwarding";
        test_name[2] = "immediates";
        test_name[3] = "store_load";
        test_name[4] = "load_use";
        test_name[5] = "nop_pc";
        test_name[6] = "data_memory";
        for (int i = 0; i < 256; i++)
            imem[i] = {isa_pkg::op_nop, 10'd0, 16'(i)}; // nop, fields from address
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fill_word(i);
            ref_dm[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++)
            ref_rf[i] = 32'd0;

        // chained so operands come from EX, MEM and WB
        add_inst(isa_pkg::op_addi, 1, 0, 16'h0123, 1);
        add_inst(isa_pkg::op_addi, 2, 0, 16'hff00, 1);
        add_rr(isa_pkg::op_add, 3, 1, 2, 1);
        add_rr(isa_pkg::op_sub, 4, 3, 1, 1);
        add_rr(isa_pkg::op_and, 5, 4, 2, 1);
        add_rr(isa_pkg::op_or, 6, 5, 3, 1);
        add_rr(isa_pkg::op_xor, 7, 6, 4, 1);
        add_rr(isa_pkg::op_slt, 8, 2, 1, 1);
        add_rr(isa_pkg::op_slt, 9, 1, 2, 1);
        add_rr(isa_pkg::op_add, 10, 8, 7, 1);

        rnd = $random(seed);
        add_inst(isa_pkg::op_lui, 11, 0, rnd[15:0], 2);
        rnd = $random(seed);
        add_inst(isa_pkg::op_addi, 12, 11, rnd[15:0], 2);
        rnd = $random(seed);
        add_inst(isa_pkg::op_addi, 13, 12, rnd[15:0] | 16'h8000, 2); // negative
        rnd = $random(seed);
        add_inst(isa_pkg::op_lui, 14, 0, rnd[15:0], 2);
        rnd = $random(seed);
        add_inst(isa_pkg::op_addi, 14, 14, rnd[15:0], 2);
        rnd = $random(seed);
        add_inst(isa_pkg::op_addi, 15, 0, rnd[15:0] | 16'h8000, 2);

        add_inst(isa_pkg::op_addi, 20, 0, 16'h0040, 3); // base address
        add_inst(isa_pkg::op_lui, 21, 0, 16'h5a5a, 3);
        add_inst(isa_pkg::op_addi, 21, 21, 16'h0c3c, 3);
        add_inst(isa_pkg::op_st, 21, 20, 16'h0008, 3);
        add_inst(isa_pkg::op_ld, 22, 20, 16'h0008, 3);

        add_inst(isa_pkg::op_ld, 23, 20, 16'h0008, 4);
        add_rr(isa_pkg::op_add, 24, 23, 1, 4);      // stalls one cycle
        add_inst(isa_pkg::op_ld, 25, 20, 16'h0008, 4);
        add_inst(isa_pkg::op_st, 25, 20, 16'h000c, 4); // store data hazard
        add_inst(isa_pkg::op_ld, 26, 20, 16'h000c, 4);
        add_rr(isa_pkg::op_sub, 27, 26, 24, 4);

        add_inst(isa_pkg::op_nop, 0, 0, 16'h0000, 5);
        add_inst(isa_pkg::op_addi, 28, 1, 16'h0001, 5);
        add_inst(isa_pkg::op_nop, 0, 0, 16'h0000, 5);
        add_inst(isa_pkg::op_nop, 0, 0, 16'h0000, 5);
        add_inst(isa_pkg::op_addi, 29, 28, 16'h0002, 5);
        add_inst(isa_pkg::op_nop, 0, 0, 16'h0000, 5);
        add_rr(isa_pkg::op_add, 30, 29, 28, 5);
        add_inst(isa_pkg::op_nop, 0, 0, 16'h0000, 5);

        foreach (prog[i]) begin
            idx = boot_pc[9:2] + 8'(i);
            imem[idx] = {prog[i].op, prog[i].rd, prog[i].rj, prog[i].imm};
            if (prog[i].has_wr) begin
                w = '{pc: boot_pc + 32'(4 * i), waddr: prog[i].rd, wdata: prog[i].value,
                      test: prog[i].test, last: 1'b0};
                exp_q.push_back(w);
            end
        end
        for (int j = 0; j < exp_q.size(); j++) begin
            w = exp_q[j];
            w.last = (j == exp_q.size() - 1) || (exp_q[j + 1].test != w.test);
            exp_q[j] = w;
        end
        limit = 4 * prog.size() + 50;

        // outputs must stay quiet while reset is held
        cur_test = 0;
        @(posedge clk);
        while (!resetn) begin
            @(negedge clk);
            if (!resetn) begin
                check_val("inst_sram_en", 32'(inst_sram_en), 32'd0);
                check_val("data_sram_en", 32'(data_sram_en), 32'd0);
                check_val("data_sram_we", 32'(data_sram_we), 32'd0);
                check_val("debug_wb_rf_we", 32'(debug_wb_rf_we), 32'd0);
            end
        end
        report_test(0);

        while (exp_q.size() != 0 && cycles < limit)
            @(negedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("writeback stopped: %0d expected register writes missing after %0d cycles",
                     exp_q.size(), cycles);
        end else begin
            repeat (8) @(negedge clk); // catch stray writes
            cur_test = 6;
            for (int i = 0; i < 64; i++)
                check_val("data_mem", dmem[i], ref_dm[i]);
            report_test(6);
        end

        clean = 0;
        for (int t = 0; t < n_tests; t++) begin
            if (test_errs[t] == 0)
                clean++;
        end
        $display("%0d checks, %0d errors, %0d of %0d tests clean, %0d cycles",
                 checks, errors, clean, n_tests, cycles);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
isa_pkg.sv
pipe_pkg.sv
alu.sv
regfile.sv
if_stage.sv
id_stage.sv
ex_stage.sv
mem_stage.sv
wb_stage.sv
mini_core.sv
tb_clk_gen.sv
tb_mini_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mini_core
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= All checks passed

SIM := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
